/* verilog/fcore_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore sizing macros
// Data width, register file depth and channel size
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FCORE_MACROS_SVH
`define FCORE_MACROS_SVH

// Width of one register word
`define FCORE_REG_WIDTH 32

// Total number of registers in the file
`define FCORE_FILE_DEPTH 64

// Registers per channel; the first one of each channel reads as zero
`define FCORE_REG_PER_CHANNEL 16

`endif

/* verilog/fcore_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore package
// Register, write, instruction and opcode types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fcore_macros.svh"

package fcore_pkg;

    // Address sized from the file depth
    typedef logic [$clog2(`FCORE_FILE_DEPTH)-1:0] reg_addr_t;

    typedef logic [`FCORE_REG_WIDTH-1:0] reg_data_t;

    // One register write, used for DMA, core writeback and result
    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        reg_data_t data;
    } reg_write_t;

    // ALU operations
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SHL,
        OP_SHR,
        OP_LDI
    } opcode_e;

    // Immediate is sign-extended to the register width for OP_LDI
    typedef struct packed {
        opcode_e     opcode;
        reg_addr_t   dest;
        reg_addr_t   src_a;
        reg_addr_t   src_b;
        logic [15:0] imm;
    } instr_t;

endpackage

/* verilog/dp_ram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dp_ram
// Simple dual-port RAM with a registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "fcore_macros.svh"

module dp_ram (
    input  logic                 clock,
    input  logic                 wr_en,
    input  fcore_pkg::reg_addr_t wr_addr,
    input  fcore_pkg::reg_data_t wr_data,
    input  fcore_pkg::reg_addr_t rd_addr,
    output fcore_pkg::reg_data_t rd_data
);

    import fcore_pkg::*;

    reg_data_t mem [`FCORE_FILE_DEPTH];

    // Read and write on the same edge; a read of the address being
    // written returns the word that was there before the write
    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/register_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register_file
// Two-read, one-write file with a DMA access port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "fcore_macros.svh"

module register_file (
    input  logic                  clock,
    input  logic                  arst_n,

    input  logic                  dma_enable,
    input  fcore_pkg::reg_write_t dma_write,
    input  fcore_pkg::reg_addr_t  dma_read_addr,
    output fcore_pkg::reg_data_t  dma_read_data,

    input  fcore_pkg::reg_addr_t  read_addr_a,
    input  fcore_pkg::reg_addr_t  read_addr_b,
    output fcore_pkg::reg_data_t  read_data_a,
    output fcore_pkg::reg_data_t  read_data_b,

    input  fcore_pkg::reg_write_t core_write
);

    import fcore_pkg::*;

    reg_write_t ram_write;
    reg_addr_t  ram_addr_a;
    reg_data_t  ram_data_a;
    reg_data_t  ram_data_b;
    logic       dma_enable_q;

    // Write source and port a address selection
    always_comb begin
        if (dma_enable) begin
            ram_write  = dma_write;
            ram_addr_a = dma_read_addr;
        end else begin
            ram_write  = core_write;
            ram_addr_a = read_addr_a;
            // Core writes to the first register of a channel store zero
            if (core_write.dest % `FCORE_REG_PER_CHANNEL == 0) begin
                ram_write.data = '0;
            end
        end
    end

    // Both copies see the same write, each serves one read port
    dp_ram mem_a (
        .clock   (clock),
        .wr_en   (ram_write.valid),
        .wr_addr (ram_write.dest),
        .wr_data (ram_write.data),
        .rd_addr (ram_addr_a),
        .rd_data (ram_data_a)
    );

    dp_ram mem_b (
        .clock   (clock),
        .wr_en   (ram_write.valid),
        .wr_addr (ram_write.dest),
        .wr_data (ram_write.data),
        .rd_addr (read_addr_b),
        .rd_data (ram_data_b)
    );

    // Delayed copy of dma_enable lines up with the RAM read latency
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dma_enable_q <= 1'b0;
        end else begin
            dma_enable_q <= dma_enable;
        end
    end

    assign read_data_a   = ram_data_a;
    assign read_data_b   = ram_data_b;
    assign dma_read_data = dma_enable_q ? ram_data_a : '0;

endmodule

/* verilog/execution_pipeline.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execution_pipeline
// Two-stage operand read, ALU and writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "fcore_macros.svh"

module execution_pipeline (
    input  logic                  clock,
    input  logic                  arst_n,

    input  logic                  instr_valid,
    input  fcore_pkg::instr_t     instr,

    output fcore_pkg::reg_addr_t  read_addr_a,
    output fcore_pkg::reg_addr_t  read_addr_b,
    input  fcore_pkg::reg_data_t  read_data_a,
    input  fcore_pkg::reg_data_t  read_data_b,

    output fcore_pkg::reg_write_t core_write
);

    import fcore_pkg::*;

    // Stage 1 holds the instruction while the operands are read
    logic        s1_valid;
    opcode_e     s1_opcode;
    reg_addr_t   s1_dest;
    logic [15:0] s1_imm;

    // Stage 2 holds the registered writeback
    logic        wb_valid;
    reg_addr_t   wb_dest;
    reg_data_t   wb_data;

    reg_data_t   alu_result;

    // Source addresses go to the RAMs in the issue cycle
    assign read_addr_a = instr.src_a;
    assign read_addr_b = instr.src_b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            s1_valid <= instr_valid;
            wb_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_opcode <= instr.opcode;
        s1_dest   <= instr.dest;
        s1_imm    <= instr.imm;
        wb_dest   <= s1_dest;
        wb_data   <= alu_result;
    end

    // Operands are valid here, one cycle after issue
    always_comb begin
        case (s1_opcode)
            OP_ADD:  alu_result = read_data_a + read_data_b;
            OP_SUB:  alu_result = read_data_a - read_data_b;
            // Only the low half of the product is kept
            OP_MUL:  alu_result = read_data_a * read_data_b;
            OP_AND:  alu_result = read_data_a & read_data_b;
            OP_OR:   alu_result = read_data_a | read_data_b;
            OP_XOR:  alu_result = read_data_a ^ read_data_b;
            OP_SHL:  alu_result = read_data_a << read_data_b[$clog2(`FCORE_REG_WIDTH)-1:0];
            OP_SHR:  alu_result = read_data_a >> read_data_b[$clog2(`FCORE_REG_WIDTH)-1:0];
            OP_LDI:  alu_result = reg_data_t'($signed(s1_imm));
            default: alu_result = '0;
        endcase
    end

    assign core_write = '{valid: wb_valid, dest: wb_dest, data: wb_data};

endmodule

/* verilog/fcore_datapath.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore_datapath
// Top level joining the pipeline and register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_datapath (
    input  logic                  clock,
    input  logic                  arst_n,

    input  logic                  instr_valid,
    input  fcore_pkg::instr_t     instr,

    input  logic                  dma_enable,
    input  fcore_pkg::reg_write_t dma_write,
    input  fcore_pkg::reg_addr_t  dma_read_addr,
    output fcore_pkg::reg_data_t  dma_read_data,

    // Copy of the core writeback
    output fcore_pkg::reg_write_t result
);

    import fcore_pkg::*;

    reg_addr_t read_addr_a;
    reg_addr_t read_addr_b;
    reg_data_t read_data_a;
    reg_data_t read_data_b;

    execution_pipeline i_execution_pipeline (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .read_addr_a (read_addr_a),
        .read_addr_b (read_addr_b),
        .read_data_a (read_data_a),
        .read_data_b (read_data_b),
        .core_write  (result)
    );

    // The writeback feeds the file and leaves the core as result
    register_file i_register_file (
        .clock         (clock),
        .arst_n        (arst_n),
        .dma_enable    (dma_enable),
        .dma_write     (dma_write),
        .dma_read_addr (dma_read_addr),
        .dma_read_data (dma_read_data),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .read_data_a   (read_data_a),
        .read_data_b   (read_data_b),
        .core_write    (result)
    );

endmodule

/* test/fcore_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore_clock_gen
// 10 ns clock and a reset held for 5 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_clock_gen (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

/* test/fcore_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore_checker
// Assertions on writeback timing, reset and zero registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps
`include "fcore_macros.svh"

module fcore_checker (
    input logic                  clock,
    input logic                  arst_n,
    input logic                  instr_valid,
    input logic                  dma_enable,
    input fcore_pkg::reg_write_t result,
    input fcore_pkg::reg_data_t  mem_a_words [`FCORE_FILE_DEPTH],
    input fcore_pkg::reg_data_t  mem_b_words [`FCORE_FILE_DEPTH]
);

    import fcore_pkg::*;

    // Every issued instruction writes back exactly two cycles later
    assert property (@(posedge clock) disable iff (!arst_n)
        instr_valid |-> ##2 result.valid)
        else $error("writeback missing two cycles after issue");

    assert property (@(posedge clock) disable iff (!arst_n)
        result.valid |-> $past(instr_valid, 2))
        else $error("writeback without an issue two cycles before");

    assert property (@(posedge clock) !arst_n |-> !result.valid)
        else $error("result valid during reset");

    // A core write to the first register of a channel leaves zero in both copies
    assert property (@(posedge clock) disable iff (!arst_n)
        (result.valid && !dma_enable
            && (result.dest % `FCORE_REG_PER_CHANNEL) == 0)
        |=> mem_a_words[$past(result.dest)] == '0
            && mem_b_words[$past(result.dest)] == '0)
        else $error("channel zero register holds nonzero data after a core write");

endmodule

bind fcore_datapath fcore_checker i_fcore_checker (
    .clock       (clock),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .dma_enable  (dma_enable),
    .result      (result),
    .mem_a_words (i_register_file.mem_a.mem),
    .mem_b_words (i_register_file.mem_b.mem)
);

/* test/fcore_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fcore_tb
// Runs the case file through the fcore datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module fcore_tb;

    import fcore_pkg::*;

    localparam int RESULT_TIMEOUT = 20;
    localparam int RESET_TIMEOUT  = 20;

    logic       clock;
    logic       arst_n;
    logic       instr_valid;
    instr_t     instr;
    logic       dma_enable;
    reg_write_t dma_write;
    reg_addr_t  dma_read_addr;
    reg_data_t  dma_read_data;
    reg_write_t result;

    // Writebacks still owed by the DUT, oldest first
    reg_write_t expected_q[$];
    int         error_count;
    int         check_count;
    logic       timed_out;

    fcore_clock_gen i_fcore_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    fcore_datapath i_fcore_datapath (
        .clock         (clock),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .dma_enable    (dma_enable),
        .dma_write     (dma_write),
        .dma_read_addr (dma_read_addr),
        .dma_read_data (dma_read_data),
        .result        (result)
    );

    task automatic check_write(input string name, input reg_write_t expected,
                               input reg_write_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input reg_data_t expected,
                              input reg_data_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    // Strobes are single-cycle, so each edge releases them first
    task automatic next_edge();
        @(posedge clock);
        instr_valid <= 1'b0;
        dma_write   <= '0;
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && !timed_out) begin
            @(posedge clock);
            waited++;
            if (waited > RESULT_TIMEOUT) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: %0d writebacks never arrived", expected_q.size());
            end
        end
    endtask

    task automatic dma_store(input reg_addr_t addr, input reg_data_t data);
        reg_write_t wr;
        wr.valid = 1'b1;
        wr.dest  = addr;
        wr.data  = data;
        next_edge();
        drain_results();
        dma_enable <= 1'b1;
        dma_write  <= wr;
    endtask

    // Read data follows the address by one cycle
    task automatic dma_check(input reg_addr_t addr, input reg_data_t expected);
        next_edge();
        drain_results();
        dma_enable    <= 1'b1;
        dma_read_addr <= addr;
        next_edge();
        next_edge();
        check_data("dma_read_data", expected, dma_read_data);
    endtask

    task automatic issue_instr(input instr_t ins, input reg_data_t expected);
        reg_write_t wb;
        wb.valid = 1'b1;
        wb.dest  = ins.dest;
        wb.data  = expected;
        next_edge();
        dma_enable  <= 1'b0;
        instr_valid <= 1'b1;
        instr       <= ins;
        expected_q.push_back(wb);
    endtask

    // Writebacks are compared in issue order
    always @(posedge clock) begin
        if (result.valid) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("Unexpected writeback to register %h", result.dest);
            end else begin
                check_write("result", expected_q.pop_front(), result);
            end
        end
    end

    initial begin
        int                fd;
        int                code;
        int                count;
        int                waited;
        logic [7:0]        kind;
        logic [3:0]        op_bits;
        reg_addr_t         dest;
        reg_addr_t         src_a;
        reg_addr_t         src_b;
        logic [15:0]       imm;
        reg_data_t         data;
        instr_t            ins;
        logic [8*160-1:0]  skip_line;

        instr_valid   = 1'b0;
        instr         = '0;
        dma_enable    = 1'b0;
        dma_write     = '0;
        dma_read_addr = '0;
        error_count   = 0;
        check_count   = 0;
        timed_out     = 1'b0;

        waited = 0;
        while (arst_n !== 1'b1 && !timed_out) begin
            @(posedge clock);
            waited++;
            if (waited > RESET_TIMEOUT) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: reset was never released");
            end
        end

        fd = $fopen("test/fcore_cases.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the case file test/fcore_cases.txt");
        end else begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1 && !timed_out) begin
                case (kind)
                    "#": code = $fgets(skip_line, fd);
                    "D": begin
                        code = $fscanf(fd, " %h %h", dest, data);
                        dma_store(dest, data);
                    end
                    "R": begin
                        code = $fscanf(fd, " %h %h", dest, data);
                        dma_check(dest, data);
                    end
                    "W": begin
                        code = $fscanf(fd, " %h", count);
                        repeat (count) next_edge();
                    end
                    "I": begin
                        code = $fscanf(fd, " %h %h %h %h %h %h",
                                       op_bits, dest, src_a, src_b, imm, data);
                        ins.opcode = opcode_e'(op_bits);
                        ins.dest   = dest;
                        ins.src_a  = src_a;
                        ins.src_b  = src_b;
                        ins.imm    = imm;
                        issue_instr(ins, data);
                    end
                    default: begin
                        error_count++;
                        $display("Unknown record kind %c in the case file", kind);
                    end
                endcase
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end

        next_edge();
        drain_results();
        repeat (3) next_edge();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+verilog
verilog/fcore_pkg.sv
verilog/dp_ram.sv
verilog/register_file.sv
verilog/execution_pipeline.sv
verilog/fcore_datapath.sv
test/fcore_clock_gen.sv
test/fcore_checker.sv
test/fcore_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the fcore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module fcore_tb -f src.f -o fcore_sim

sim_out=$(./obj_dir/fcore_sim) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* test/fcore_cases.txt */
# Hex columns. D addr data | R addr expected_data | W idle_cycles
# I opcode dest src_a src_b imm expected_result (opcode ADD=0 .. LDI=8)
D 01 00000007
D 02 00000003
D 03 F0F0F0F0
D 04 0FF00FF0
D 05 80000001
D 06 00000004
D 00 12345678
D 10 CAFEBABE
R 00 12345678
R 10 CAFEBABE
R 03 F0F0F0F0
# One instruction per cycle over every opcode
I 0 11 01 02 0000 0000000A
I 1 12 01 02 0000 00000004
I 1 1C 02 01 0000 FFFFFFFC
I 2 13 01 02 0000 00000015
I 2 1B 03 06 0000 C3C3C3C0
I 3 14 03 04 0000 00F000F0
I 4 15 03 04 0000 FFF0FFF0
I 5 16 03 04 0000 FF00FF00
I 6 17 05 06 0000 00000010
I 7 18 05 06 0000 08000000
I 8 19 00 00 FFFE FFFFFFFE
I 8 1A 00 00 1234 00001234
R 11 0000000A
R 1C FFFFFFFC
R 1B C3C3C3C0
R 18 08000000
R 19 FFFFFFFE
# Zero-register dests: result shows the ALU value, the file keeps zero
I 0 00 01 02 0000 0000000A
I 8 10 00 00 7777 00007777
I 4 20 03 04 0000 FFF0FFF0
I 0 30 01 01 0000 0000000E
R 00 00000000
R 10 00000000
R 20 00000000
R 30 00000000
# DMA overwrites earlier results, later instructions use the new values
D 11 00000064
D 12 00000020
R 11 00000064
I 0 21 11 12 0000 00000084
W 02
I 0 22 21 21 0000 00000108
R 21 00000084
R 22 00000108
W 04
